// File: sim/pic_cases.txt
# op arg value, all hex; arg is a0 for write/read, the line for raise/drop, cycles for idle
# value is the data for write, else the expected data_out, int_req or init state
write 0 13
write 1 40
write 1 01
state 0 0
read 1 ff
write 1 f0
read 1 f0
# masked request on line 5
raise 5 0
idle 4 0
read 0 20
intr 0 0
write 1 00
wait 0 1
# line 2 outranks line 5
raise 2 0
idle 4 0
inta 0 42
write 0 0b
read 0 04
write 0 0a
read 0 20
intr 0 0
# non-specific then specific EOI
write 0 20
inta 0 45
write 0 0b
read 0 20
write 0 65
idle 2 0
read 0 00
drop 2 0
drop 5 0
# set priority to level 4, then rotate on EOI
write 0 c4
raise 1 0
raise 6 0
idle 4 0
inta 0 46
write 0 a0
raise 7 0
idle 4 0
inta 0 47
write 0 20
# poll with line 1 pending, then with nothing pending
write 0 0c
read 0 81
write 0 0b
read 0 02
write 0 20
write 0 0c
read 0 00

// File: filelist.f
+incdir+design
design/pic_cmd_pkg.sv
design/pic_bus_pkg.sv
design/pic_command_decoder.sv
design/pic_request_line.sv
design/pic_priority_resolver.sv
design/pic_ack_sequencer.sv
design/pic_top.sv
sim/tb_pic.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the interrupt controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f filelist.f --top-module tb_pic -o tb_pic

output="$(./obj_dir/tb_pic)"
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: sim/tb_pic.sv
/*
 * Testbench for the interrupt controller top level
 * Replays sim/pic_cases.txt, drives the CPU bus, irq and INTA
 * Compare tasks for bytes, bits and the init state
 */
`timescale 1ns/100ps
`include "pic_settings.svh"

module tb_pic;
    import pic_cmd_pkg::*;
    import pic_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;

    logic                      clock;
    logic                      reset;
    cpu_bus_t                  bus;
    logic                      inta_n;
    logic [`PIC_NUM_LINES-1:0] irq;
    logic                      int_req;
    logic [`PIC_DATA_BITS-1:0] data_out;
    logic                      data_valid;

    int checks;
    int mismatches;
    int timeouts;
    int other_errors;

    pic_top i_pic_top (
        .clock, .reset, .bus, .inta_n, .irq, .int_req, .data_out, .data_valid
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic drive_slot();
        @(posedge clock);
        #1;
    endtask

    task automatic check_byte(input string name, input logic [`PIC_DATA_BITS-1:0] actual,
                              input logic [`PIC_DATA_BITS-1:0] expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("FAILED %s: got 0x%02h, expected 0x%02h", name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic check_state(input init_state_t actual, input init_state_t expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("FAILED init_state: got 0x%0h, expected 0x%0h", actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("ERROR: timed out waiting for %s", what);
    endtask

    task automatic bus_write(input logic a0, input logic [`PIC_DATA_BITS-1:0] data);
        drive_slot();
        bus.wr   = 1'b1;
        bus.a0   = a0;
        bus.data = data;
        drive_slot();
        bus.wr   = 1'b0;
    endtask

    task automatic bus_read_check(input logic a0, input logic [`PIC_DATA_BITS-1:0] expected);
        drive_slot();
        bus.rd = 1'b1;
        bus.a0 = a0;
        @(negedge clock);
        check_bit("data_valid", data_valid, 1'b1);
        check_byte("data_out", data_out, expected);
        drive_slot();
        bus.rd = 1'b0;
    endtask

    task automatic wait_int_req(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (int_req !== level && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (int_req !== level) begin
            report_timeout("int_req to reach the expected level");
        end
    endtask

    // Two INTA pulses, vector is checked during the second one
    task automatic inta_cycle(input logic [`PIC_DATA_BITS-1:0] expected);
        int cycles;
        cycles = 0;
        wait_int_req(1'b1);
        drive_slot();
        inta_n = 1'b0;
        drive_slot();
        drive_slot();
        inta_n = 1'b1;
        drive_slot();
        inta_n = 1'b0;
        @(negedge clock);
        while (!data_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (!data_valid) begin
            report_timeout("the interrupt vector in the second INTA pulse");
        end else begin
            check_byte("data_out", data_out, expected);
        end
        drive_slot();
        inta_n = 1'b1;
    endtask

    task automatic run_step(input string op, input logic [31:0] arg, input logic [31:0] value);
        case (op)
            "write": bus_write(arg[0], value[`PIC_DATA_BITS-1:0]);
            "read":  bus_read_check(arg[0], value[`PIC_DATA_BITS-1:0]);
            "raise": begin
                drive_slot();
                irq[arg[2:0]] = 1'b1;
            end
            "drop": begin
                drive_slot();
                irq[arg[2:0]] = 1'b0;
            end
            "inta":  inta_cycle(value[`PIC_DATA_BITS-1:0]);
            "wait":  wait_int_req(value[0]);
            "intr": begin
                @(negedge clock);
                check_bit("int_req", int_req, value[0]);
            end
            "state": begin
                @(negedge clock);
                check_state(i_pic_top.i_command_decoder.init_state, init_state_t'(value[1:0]));
            end
            "idle":  repeat (arg) @(posedge clock);
            default: begin
                other_errors++;
                $display("ERROR: unknown operation %s in the case file", op);
            end
        endcase
    endtask

    initial begin
        int               fd;
        int               n;
        string            op;
        logic [31:0]      arg;
        logic [31:0]      value;
        logic [8*128-1:0] rest_of_line;
        bit               done;
        reset        = 1'b1;
        bus          = '0;
        inta_n       = 1'b1;
        irq          = '0;
        checks       = 0;
        mismatches   = 0;
        timeouts     = 0;
        other_errors = 0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        fd = $fopen("sim/pic_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: could not open the case file sim/pic_cases.txt");
        end else begin
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, "%s", op);
                if (n != 1) begin
                    done = 1'b1;
                end else if (op == "#") begin
                    n = $fgets(rest_of_line, fd);
                end else begin
                    n = $fscanf(fd, "%h %h", arg, value);
                    if (n != 2) begin
                        other_errors++;
                        done = 1'b1;
                        $display("ERROR: operation %s is missing its operands", op);
                    end else begin
                        run_step(op, arg, value);
                    end
                end
            end
            $fclose(fd);
        end
        $display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
                 checks, mismatches, timeouts, other_errors);
        if (mismatches + timeouts + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: design/pic_top.sv
/*
 * Interrupt controller top level
 * Decoder, eight request lines, resolver and sequencer
 */
`timescale 1ns/100ps
`include "pic_settings.svh"

module pic_top (
    input  logic                       clock,
    input  logic                       reset,
    input  pic_bus_pkg::cpu_bus_t      bus,
    input  logic                       inta_n,
    input  logic [`PIC_NUM_LINES-1:0]  irq,
    output logic                       int_req,
    output logic [`PIC_DATA_BITS-1:0]  data_out,
    output logic                       data_valid
);
    import pic_cmd_pkg::*;
    import pic_bus_pkg::*;

    logic [`PIC_NUM_LINES-1:0]                 mask;
    logic                                      init;
    logic [`PIC_DATA_BITS-`PIC_LEVEL_BITS-1:0] vector_base;
    read_sel_t                                 read_sel;
    logic                                      poll_cmd;
    eoi_cmd_t                                  eoi_cmd;
    line_ctrl_t   [`PIC_NUM_LINES-1:0]         line_ctrl;
    line_status_t [`PIC_NUM_LINES-1:0]         line_status;
    logic [`PIC_NUM_LINES-1:0]                 grant;
    logic [`PIC_LEVEL_BITS-1:0]                grant_level;
    logic [`PIC_NUM_LINES-1:0]                 clear_isr;
    logic                                      latch;

    pic_command_decoder i_command_decoder (
        .clock, .reset, .bus, .mask, .init, .vector_base, .read_sel, .poll_cmd, .eoi_cmd
    );

    for (genvar g = 0; g < `PIC_NUM_LINES; g++) begin : g_line
        // Clear comes from the resolver, the rest from the decoder
        assign line_ctrl[g].mask      = mask[g];
        assign line_ctrl[g].clear_isr = clear_isr[g];
        assign line_ctrl[g].init      = init;

        pic_request_line i_request_line (
            .clock, .reset, .irq(irq[g]), .ctrl(line_ctrl[g]), .grant(grant[g]),
            .latch, .status(line_status[g])
        );
    end

    pic_priority_resolver i_priority_resolver (
        .clock, .reset, .status(line_status), .eoi_cmd, .grant, .grant_level, .clear_isr
    );

    pic_ack_sequencer i_ack_sequencer (
        .clock, .reset, .bus, .inta_n, .status(line_status), .grant_level, .mask,
        .vector_base, .read_sel, .poll_cmd, .latch, .int_req, .data_out, .data_valid
    );

endmodule

// File: design/pic_ack_sequencer.sv
/*
 * INTA and poll state machine
 * Interrupt request output, ISR latch pulse
 * Read data mux for vector, poll word, mask, IRR and ISR
 */
`timescale 1ns/100ps
`include "pic_settings.svh"

module pic_ack_sequencer (
    input  logic                                           clock,
    input  logic                                           reset,
    input  pic_bus_pkg::cpu_bus_t                          bus,
    input  logic                                           inta_n,
    input  pic_bus_pkg::line_status_t [`PIC_NUM_LINES-1:0] status,
    input  logic [`PIC_LEVEL_BITS-1:0]                     grant_level,
    input  logic [`PIC_NUM_LINES-1:0]                      mask,
    input  logic [`PIC_DATA_BITS-`PIC_LEVEL_BITS-1:0]      vector_base,
    input  pic_cmd_pkg::read_sel_t                         read_sel,
    input  logic                                           poll_cmd,
    output logic                                           latch,
    output logic                                           int_req,
    output logic [`PIC_DATA_BITS-1:0]                      data_out,
    output logic                                           data_valid
);
    import pic_cmd_pkg::*;
    import pic_bus_pkg::*;

    localparam int LB  = `PIC_LEVEL_BITS;
    localparam int PAD = `PIC_DATA_BITS - 1 - `PIC_LEVEL_BITS;

    ack_state_t               state;
    ack_state_t               state_next;
    logic                     inta_q;
    logic                     inta_fall;
    logic                     inta_rise;
    logic                     rd_q;
    logic                     poll_done;
    logic                     has_req;
    logic [LB-1:0]            ack_level;
    logic [LB-1:0]            poll_level;
    logic [`PIC_NUM_LINES-1:0] irr_vec;
    logic [`PIC_NUM_LINES-1:0] isr_vec;

    assign inta_fall = inta_q && !inta_n;
    assign inta_rise = !inta_q && inta_n;

    // Resolver points at a blocking ISR line when nothing wins
    assign has_req    = status[grant_level].pending && !status[grant_level].isr;
    assign poll_level = has_req ? grant_level : '0;
    assign poll_done  = (state == POLL) && rd_q && !bus.rd;
    assign latch      = ((state == WAIT_ACK) && inta_fall) || (poll_done && has_req);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (poll_cmd) state_next = POLL;
                      else if (has_req) state_next = WAIT_ACK;
            WAIT_ACK: if (poll_cmd) state_next = POLL;
                      else if (inta_fall) state_next = ACK1;
                      else if (!has_req) state_next = IDLE;
            ACK1:     if (inta_rise) state_next = ACK2;
            ACK2:     if (inta_rise) state_next = IDLE;
            POLL:     if (poll_done) state_next = IDLE;
            default:  state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= IDLE;
            inta_q  <= 1'b1;
            rd_q    <= 1'b0;
            int_req <= 1'b0;
        end else begin
            state   <= state_next;
            inta_q  <= inta_n;
            rd_q    <= bus.rd && !bus.a0;
            int_req <= has_req || (state_next == ACK1) || (state_next == ACK2);
        end
    end

    always_ff @(posedge clock) begin
        if (latch) begin
            ack_level <= grant_level;
        end
    end

    always_comb begin
        for (int i = 0; i < `PIC_NUM_LINES; i++) begin
            irr_vec[i] = status[i].irr;
            isr_vec[i] = status[i].isr;
        end
    end

    always_comb begin
        data_out   = '0;
        data_valid = 1'b0;
        if ((state == ACK2) && !inta_n) begin
            data_out   = {vector_base, ack_level};
            data_valid = 1'b1;
        end else if (bus.rd) begin
            data_valid = 1'b1;
            if (bus.a0) begin
                data_out = mask;
            end else if (state == POLL) begin
                data_out = {has_req, {PAD{1'b0}}, poll_level};
            end else begin
                data_out = (read_sel == SEL_ISR) ? isr_vec : irr_vec;
            end
        end
    end

    // Read and INTA never overlap while data is driven
    data_only_on_strobe: assert property (
        @(posedge clock) disable iff (reset)
        data_valid |-> (bus.rd != !inta_n)
    ) else $error("data driven without exactly one of read and INTA");

endmodule

// File: design/pic_priority_resolver.sv
/*
 * Rotating priority resolver
 * Grant of the best pending line, top in-service level
 * EOI line select and lowest-priority pointer
 */
`timescale 1ns/100ps
`include "pic_settings.svh"

module pic_priority_resolver (
    input  logic                                           clock,
    input  logic                                           reset,
    input  pic_bus_pkg::line_status_t [`PIC_NUM_LINES-1:0] status,
    input  pic_cmd_pkg::eoi_cmd_t                          eoi_cmd,
    output logic [`PIC_NUM_LINES-1:0]                      grant,
    output logic [`PIC_LEVEL_BITS-1:0]                     grant_level,
    output logic [`PIC_NUM_LINES-1:0]                      clear_isr
);
    import pic_cmd_pkg::*;
    import pic_bus_pkg::*;

    localparam int LB = `PIC_LEVEL_BITS;

    logic [LB-1:0] lowest;
    logic [LB-1:0] scan_level;
    logic [LB-1:0] win_level;
    logic [LB-1:0] top_isr;
    logic          found;
    logic          isr_found;

    // Walk from just after the lowest line, first in-service line stops the search
    always_comb begin
        grant      = '0;
        scan_level = '0;
        win_level  = '0;
        top_isr    = '0;
        found      = 1'b0;
        isr_found  = 1'b0;
        for (int i = 1; i <= `PIC_NUM_LINES; i++) begin
            scan_level = lowest + LB'(i);
            if (status[scan_level].isr && !isr_found) begin
                isr_found = 1'b1;
                top_isr   = scan_level;
            end
            if (!found && !isr_found && status[scan_level].pending) begin
                found             = 1'b1;
                grant[scan_level] = 1'b1;
                win_level         = scan_level;
            end
        end
        // Blocking in-service line when nothing wins
        grant_level = found ? win_level : top_isr;
    end

    always_comb begin
        clear_isr = '0;
        if (eoi_cmd.valid) begin
            case (eoi_cmd.op)
                OP_EOI_NONSPEC, OP_ROT_NONSPEC: clear_isr[top_isr]       = isr_found;
                OP_EOI_SPEC, OP_ROT_SPEC:       clear_isr[eoi_cmd.level] = 1'b1;
                default:                        clear_isr                = '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lowest <= '1;
        end else if (eoi_cmd.valid) begin
            case (eoi_cmd.op)
                OP_ROT_NONSPEC:               lowest <= isr_found ? top_isr : lowest;
                OP_ROT_SPEC, OP_SET_PRIORITY: lowest <= eoi_cmd.level;
                default:                      lowest <= lowest;
            endcase
        end
    end

endmodule

// File: design/pic_request_line.sv
/*
 * One interrupt request line
 * Edge detect, IRR, ISR and registered status
 */
`timescale 1ns/100ps

module pic_request_line (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      irq,
    input  pic_bus_pkg::line_ctrl_t   ctrl,
    input  logic                      grant,
    input  logic                      latch,
    output pic_bus_pkg::line_status_t status
);

    logic irq_sample;
    logic irq_prev;
    logic irq_rise;
    logic take;
    logic irr_next;
    logic isr_next;

    assign irq_rise = irq_sample && !irq_prev;

    // Acknowledge moves this request into service
    assign take = latch && grant;

    assign irr_next = irq_rise || (status.irr && !take);
    assign isr_next = take || (status.isr && !ctrl.clear_isr);

    always_ff @(posedge clock) begin
        if (reset || ctrl.init) begin
            irq_sample <= 1'b0;
            irq_prev   <= 1'b0;
            status     <= '0;
        end else begin
            irq_sample     <= irq;
            irq_prev       <= irq_sample;
            status.irr     <= irr_next;
            status.isr     <= isr_next;
            // Follows the mask one cycle late
            status.pending <= irr_next && !ctrl.mask;
        end
    end

    // EOI from the CPU never lands on a line being acknowledged
    no_take_and_clear: assert property (
        @(posedge clock) disable iff (reset)
        !(take && ctrl.clear_isr)
    ) else $error("line latched and cleared in the same cycle");

endmodule

// File: design/pic_command_decoder.sv
/*
 * Write decode for ICW1, ICW2, ICW4 and OCW1 to OCW3
 * Init sequence, vector base, mask and read select registers
 * One-cycle init, poll and EOI command pulses
 */
`timescale 1ns/100ps
`include "pic_settings.svh"

module pic_command_decoder (
    input  logic                                      clock,
    input  logic                                      reset,
    input  pic_bus_pkg::cpu_bus_t                     bus,
    output logic [`PIC_NUM_LINES-1:0]                 mask,
    output logic                                      init,
    output logic [`PIC_DATA_BITS-`PIC_LEVEL_BITS-1:0] vector_base,
    output pic_cmd_pkg::read_sel_t                    read_sel,
    output logic                                      poll_cmd,
    output pic_cmd_pkg::eoi_cmd_t                     eoi_cmd
);
    import pic_cmd_pkg::*;
    import pic_bus_pkg::*;

    init_state_t init_state;
    logic        icw4_needed;
    icw1_t       icw1;
    ocw2_t       ocw2;
    ocw3_t       ocw3;
    logic        cmd_port_wr;
    logic        data_port_wr;
    logic        in_ready;
    logic        icw1_wr;
    logic        ocw1_wr;
    logic        ocw2_wr;
    logic        ocw3_wr;

    assign icw1 = icw1_t'(bus.data);
    assign ocw2 = ocw2_t'(bus.data);
    assign ocw3 = ocw3_t'(bus.data);

    assign cmd_port_wr  = bus.wr && !bus.a0;
    assign data_port_wr = bus.wr && bus.a0;
    assign in_ready     = (init_state == READY);

    // ICW1 restarts init at any time and OCWs count only once init is done
    assign icw1_wr = cmd_port_wr && icw1.one;
    assign ocw2_wr = cmd_port_wr && (ocw2.tag == 2'b00) && in_ready;
    assign ocw3_wr = cmd_port_wr && (ocw3.tag == 2'b01) && in_ready;
    assign ocw1_wr = data_port_wr && in_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            init_state  <= READY;
            icw4_needed <= 1'b0;
        end else if (icw1_wr) begin
            init_state  <= WAIT_ICW2;
            icw4_needed <= icw1.ic4;
        end else if (data_port_wr) begin
            case (init_state)
                WAIT_ICW2: init_state <= icw4_needed ? WAIT_ICW4 : READY;
                // ICW4 contents are accepted and dropped
                WAIT_ICW4: init_state <= READY;
                default:   init_state <= init_state;
            endcase
        end
    end

    // Vector bits T7..T3
    always_ff @(posedge clock) begin
        if (data_port_wr && (init_state == WAIT_ICW2)) begin
            vector_base <= bus.data[`PIC_DATA_BITS-1:`PIC_LEVEL_BITS];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mask     <= '1;
            read_sel <= SEL_IRR;
        end else begin
            if (ocw1_wr) begin
                mask <= bus.data;
            end
            if (ocw3_wr && ocw3.rr) begin
                read_sel <= ocw3.ris ? SEL_ISR : SEL_IRR;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            init          <= 1'b0;
            poll_cmd      <= 1'b0;
            eoi_cmd.valid <= 1'b0;
            eoi_cmd.op    <= OP_NONE;
            eoi_cmd.level <= '0;
        end else begin
            init          <= icw1_wr;
            poll_cmd      <= ocw3_wr && ocw3.poll;
            eoi_cmd.valid <= ocw2_wr;
            eoi_cmd.op    <= ocw2_decode(ocw2.cmd);
            eoi_cmd.level <= ocw2.level;
        end
    end

    // A held strobe would step the init sequence twice
    wr_one_cycle: assert property (
        @(posedge clock) disable iff (reset)
        bus.wr |=> !bus.wr
    ) else $error("write strobe held longer than one cycle");

endmodule

// File: design/pic_bus_pkg.sv
/*
 * CPU bus struct
 * Per-line control and status structs
 */
`include "pic_settings.svh"

package pic_bus_pkg;

    // Write strobe lasts one cycle, read strobe may be held
    typedef struct packed {
        logic                      wr;
        logic                      rd;
        logic                      a0;
        logic [`PIC_DATA_BITS-1:0] data;
    } cpu_bus_t;

    typedef struct packed {
        logic mask;
        logic clear_isr;
        logic init;
    } line_ctrl_t;

    // All fields come straight from flops in the line cell
    typedef struct packed {
        logic pending;
        logic irr;
        logic isr;
    } line_status_t;

endpackage

// File: design/pic_cmd_pkg.sv
/*
 * Command word layouts for ICW1, OCW2 and OCW3
 * Init sequence, OCW2 opcode, read select and acknowledge enums
 * EOI command struct and OCW2 opcode decode
 */
`include "pic_settings.svh"

package pic_cmd_pkg;

    typedef enum logic [1:0] {READY, WAIT_ICW2, WAIT_ICW4} init_state_t;

    // Values follow OCW2 bits 7..5 (R, SL, EOI)
    typedef enum logic [2:0] {
        OP_NONE         = 3'b000,
        OP_EOI_NONSPEC  = 3'b001,
        OP_EOI_SPEC     = 3'b011,
        OP_ROT_NONSPEC  = 3'b101,
        OP_SET_PRIORITY = 3'b110,
        OP_ROT_SPEC     = 3'b111
    } ocw2_op_t;

    typedef enum logic {SEL_IRR, SEL_ISR} read_sel_t;

    typedef enum logic [2:0] {IDLE, WAIT_ACK, ACK1, ACK2, POLL} ack_state_t;

    typedef struct packed {
        logic                       valid;
        ocw2_op_t                   op;
        logic [`PIC_LEVEL_BITS-1:0] level;
    } eoi_cmd_t;

    typedef struct packed {
        logic [2:0] addr_hi;
        logic       one;
        logic       ltim;
        logic       adi;
        logic       sngl;
        logic       ic4;
    } icw1_t;

    typedef struct packed {
        logic [2:0]                 cmd;
        logic [1:0]                 tag;
        logic [`PIC_LEVEL_BITS-1:0] level;
    } ocw2_t;

    typedef struct packed {
        logic       d7;
        logic [1:0] smm;
        logic [1:0] tag;
        logic       poll;
        logic       rr;
        logic       ris;
    } ocw3_t;

    // AEOI rotate controls and the no-op code map to OP_NONE
    function automatic ocw2_op_t ocw2_decode(input logic [2:0] bits);
        ocw2_op_t op;
        case (bits)
            3'b001:  op = OP_EOI_NONSPEC;
            3'b011:  op = OP_EOI_SPEC;
            3'b101:  op = OP_ROT_NONSPEC;
            3'b110:  op = OP_SET_PRIORITY;
            3'b111:  op = OP_ROT_SPEC;
            default: op = OP_NONE;
        endcase
        return op;
    endfunction

endpackage

// File: design/pic_settings.svh
/*
 * Controller size macros
 * Request line count, line number width, CPU data width
 */
`ifndef PIC_SETTINGS_SVH
`define PIC_SETTINGS_SVH

// Request lines
`define PIC_NUM_LINES  8

// Bits to name one line
`define PIC_LEVEL_BITS 3

// CPU data bus
`define PIC_DATA_BITS  8

`endif
